// ==== source/filter_pkg.sv ====
// ------------------------------
// Filter engine package
// Widths, packet type, opcodes and control states
// shared by the filter pipeline
// ------------------------------

package filter_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    typedef logic [31:0] data_t;
    typedef logic [3:0]  route_t;
    typedef logic [15:0] count_t;

    // Data in the upper bits, route in the lower bits
    typedef struct packed {
        data_t  data;
        route_t route;
    } packet_t;

    // ------------------------------
    // Opcodes and states
    // ------------------------------
    typedef enum logic [1:0] {
        OP_EQ = 2'd0,
        OP_NE = 2'd1,
        OP_LT = 2'd2,
        OP_GT = 2'd3
    } filter_op_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_CFG_REQ  = 3'd1,
        ST_CFG_WAIT = 3'd2,
        ST_BUSY     = 3'd3,
        ST_PAUSE    = 3'd4,
        ST_DONE     = 3'd5
    } ctrl_state_e;

    // FIFO sizing
    localparam int FIFO_DEPTH_DEFAULT  = 16;
    // Leaves headroom for the three packets in flight
    localparam int PROG_THRESH_DEFAULT = 12;

endpackage

// ==== source/sync_fifo.sv ====
// ------------------------------
// Synchronous FIFO
// Circular buffer with registered read data and valid,
// plus empty, full and prog_full flags
// ------------------------------
`timescale 1ns/100ps

module sync_fifo
    import filter_pkg::*;
#(
    parameter int WIDTH       = $bits(packet_t),
    parameter int DEPTH       = FIFO_DEPTH_DEFAULT,
    parameter int PROG_THRESH = PROG_THRESH_DEFAULT
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_do;
    logic             rd_do;

    assign wr_do     = wr_en & ~full;
    assign rd_do     = rd_en & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (wr_do) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_do) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_do, rd_do})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= rd_do;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_do) begin
            mem[wr_ptr] <= din;
        end
        if (rd_do) begin
            dout <= mem[rd_ptr];
        end
    end

    a_no_write_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(wr_en && full));
    a_no_read_empty: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(rd_en && empty));

endmodule

// ==== source/filter_control.sv ====
// ------------------------------
// Filter run control
// Requests and holds the configuration, issues pops,
// pauses on back-pressure and raises done
// ------------------------------
`timescale 1ns/100ps

module filter_control
    import filter_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       start,
    input  count_t     packet_count,
    input  logic       config_valid,
    input  filter_op_e config_op,
    input  data_t      config_threshold,
    input  logic       config_invert,
    input  logic       config_conditional,
    input  route_t     config_if_route,
    input  route_t     config_else_route,
    input  logic       in_empty,
    input  logic       out_prog_full,
    input  logic       compare_valid,
    input  logic       route_valid,
    output logic       config_request,
    output logic       pop,
    output filter_op_e cfg_op,
    output data_t      cfg_threshold,
    output logic       cfg_invert,
    output logic       cfg_conditional,
    output route_t     cfg_if_route,
    output route_t     cfg_else_route,
    output logic       done
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    count_t      remaining;
    // Mirrors the input FIFO read valid
    logic        pop_q;
    logic        drained;

    assign pop = (state == ST_BUSY) & ~in_empty & ~out_prog_full & (remaining != '0);
    assign drained = (remaining == '0) & ~pop_q & ~compare_valid & ~route_valid;
    assign config_request = (state == ST_CFG_REQ);
    assign done = (state == ST_DONE);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE, ST_DONE: if (start) next_state = ST_CFG_REQ;
            ST_CFG_REQ:       next_state = ST_CFG_WAIT;
            ST_CFG_WAIT:      if (config_valid) next_state = ST_BUSY;
            ST_BUSY: begin
                if (drained) begin
                    next_state = ST_DONE;
                end else if (out_prog_full) begin
                    next_state = ST_PAUSE;
                end
            end
            ST_PAUSE:         if (!out_prog_full) next_state = ST_BUSY;
            default:          next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state     <= ST_IDLE;
            remaining <= '0;
            pop_q     <= 1'b0;
        end else begin
            state <= next_state;
            pop_q <= pop;
            if ((state == ST_IDLE || state == ST_DONE) && start) begin
                remaining <= packet_count;
            end else if (pop) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // Configuration held for the whole run
    always_ff @(posedge ap_clk) begin
        if (state == ST_CFG_WAIT && config_valid) begin
            cfg_op          <= config_op;
            cfg_threshold   <= config_threshold;
            cfg_invert      <= config_invert;
            cfg_conditional <= config_conditional;
            cfg_if_route    <= config_if_route;
            cfg_else_route  <= config_else_route;
        end
    end

    // Configuration only arrives in answer to a request
    a_config_when_waiting: assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_valid |-> state == ST_CFG_WAIT);

endmodule

// ==== source/filter_compare_stage.sv ====
// ------------------------------
// Compare stage
// Registers a popped packet with its filter flag
// ------------------------------
`timescale 1ns/100ps

module filter_compare_stage
    import filter_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       in_valid,
    input  packet_t    in_packet,
    input  filter_op_e cfg_op,
    input  data_t      cfg_threshold,
    input  logic       cfg_invert,
    output logic       stage_valid,
    output packet_t    stage_packet,
    output logic       stage_flag
);

    logic cmp_result;

    // ------------------------------
    // Comparison against threshold
    // ------------------------------
    always_comb begin
        case (cfg_op)
            OP_EQ:   cmp_result = (in_packet.data == cfg_threshold);
            OP_NE:   cmp_result = (in_packet.data != cfg_threshold);
            // Unsigned compares
            OP_LT:   cmp_result = (in_packet.data < cfg_threshold);
            OP_GT:   cmp_result = (in_packet.data > cfg_threshold);
            default: cmp_result = 1'b0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // Payload and flag
    always_ff @(posedge ap_clk) begin
        stage_packet <= in_packet;
        stage_flag   <= cmp_result ^ cfg_invert;
    end

endmodule

// ==== source/filter_route_stage.sv ====
// ------------------------------
// Route stage
// Decides forwarding and rewrites the route
// in conditional mode
// ------------------------------
`timescale 1ns/100ps

module filter_route_stage
    import filter_pkg::*;
(
    input  logic    ap_clk,
    input  logic    areset_generator,
    input  logic    stage_valid,
    input  packet_t stage_packet,
    input  logic    stage_flag,
    input  logic    cfg_conditional,
    input  route_t  cfg_if_route,
    input  route_t  cfg_else_route,
    output logic    out_wr_en,
    output packet_t out_packet
);

    logic   forward;
    route_t next_route;

    // Conditional mode forwards everything
    assign forward = stage_valid & (cfg_conditional | stage_flag);

    always_comb begin
        if (cfg_conditional) begin
            next_route = stage_flag ? cfg_if_route : cfg_else_route;
        end else begin
            next_route = stage_packet.route;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_wr_en <= 1'b0;
        end else begin
            out_wr_en <= forward;
        end
    end

    // Data passes through untouched
    always_ff @(posedge ap_clk) begin
        out_packet.data  <= stage_packet.data;
        out_packet.route <= next_route;
    end

endmodule

// ==== source/filter_cond_engine.sv ====
// ------------------------------
// Filter engine top level
// Input FIFO, control, compare and route stages,
// output FIFO
// ------------------------------
`timescale 1ns/100ps

module filter_cond_engine
    import filter_pkg::*;
#(
    parameter int FIFO_DEPTH  = FIFO_DEPTH_DEFAULT,
    parameter int PROG_THRESH = PROG_THRESH_DEFAULT
) (
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       start,
    input  count_t     packet_count,
    input  logic       config_valid,
    input  filter_op_e config_op,
    input  data_t      config_threshold,
    input  logic       config_invert,
    input  logic       config_conditional,
    input  route_t     config_if_route,
    input  route_t     config_else_route,
    input  logic       in_valid,
    input  data_t      in_data,
    input  route_t     in_route,
    input  logic       out_ready,
    output logic       in_full,
    output logic       config_request,
    output logic       out_valid,
    output data_t      out_data,
    output route_t     out_route,
    output logic       done
);

    // ------------------------------
    // Interconnect
    // ------------------------------
    packet_t    in_packet;
    packet_t    fifo_packet;
    packet_t    cmp_packet;
    packet_t    rt_packet;
    packet_t    out_packet;
    logic       pop;
    logic       fifo_valid;
    logic       in_empty;
    logic       cmp_valid;
    logic       cmp_flag;
    logic       rt_wr_en;
    logic       out_rd_en;
    logic       out_empty;
    logic       out_full;
    logic       out_prog_full;
    filter_op_e cfg_op;
    data_t      cfg_threshold;
    logic       cfg_invert;
    logic       cfg_conditional;
    route_t     cfg_if_route;
    route_t     cfg_else_route;

    assign in_packet.data  = in_data;
    assign in_packet.route = in_route;
    assign out_data        = out_packet.data;
    assign out_route       = out_packet.route;
    // Consumer pops only when there is something to read
    assign out_rd_en       = out_ready & ~out_empty;

    sync_fifo #(
        .WIDTH      ($bits(packet_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_in_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (in_valid),
        .din             (in_packet),
        .rd_en           (pop),
        .dout            (fifo_packet),
        .valid           (fifo_valid),
        .empty           (in_empty),
        .full            (in_full),
        .prog_full       ()
    );

    filter_control u_control (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .packet_count      (packet_count),
        .config_valid      (config_valid),
        .config_op         (config_op),
        .config_threshold  (config_threshold),
        .config_invert     (config_invert),
        .config_conditional(config_conditional),
        .config_if_route   (config_if_route),
        .config_else_route (config_else_route),
        .in_empty          (in_empty),
        .out_prog_full     (out_prog_full),
        .compare_valid     (cmp_valid),
        .route_valid       (rt_wr_en),
        .config_request    (config_request),
        .pop               (pop),
        .cfg_op            (cfg_op),
        .cfg_threshold     (cfg_threshold),
        .cfg_invert        (cfg_invert),
        .cfg_conditional   (cfg_conditional),
        .cfg_if_route      (cfg_if_route),
        .cfg_else_route    (cfg_else_route),
        .done              (done)
    );

    filter_compare_stage u_compare (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .in_valid        (fifo_valid),
        .in_packet       (fifo_packet),
        .cfg_op          (cfg_op),
        .cfg_threshold   (cfg_threshold),
        .cfg_invert      (cfg_invert),
        .stage_valid     (cmp_valid),
        .stage_packet    (cmp_packet),
        .stage_flag      (cmp_flag)
    );

    filter_route_stage u_route (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .stage_valid     (cmp_valid),
        .stage_packet    (cmp_packet),
        .stage_flag      (cmp_flag),
        .cfg_conditional (cfg_conditional),
        .cfg_if_route    (cfg_if_route),
        .cfg_else_route  (cfg_else_route),
        .out_wr_en       (rt_wr_en),
        .out_packet      (rt_packet)
    );

    sync_fifo #(
        .WIDTH      ($bits(packet_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (rt_wr_en),
        .din             (rt_packet),
        .rd_en           (out_rd_en),
        .dout            (out_packet),
        .valid           (out_valid),
        .empty           (out_empty),
        .full            (out_full),
        .prog_full       (out_prog_full)
    );

    // Pops stop at prog_full, so the packets in flight always fit
    a_out_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_full |-> !rt_wr_en);

endmodule

// ==== testbench/tb_filter_cond_engine.sv ====
// ------------------------------
// Filter engine testbench
// Runs packet vectors from a file through the engine,
// checks outputs, done and config_request
// ------------------------------
`timescale 1ns/100ps

module tb_filter_cond_engine
    import filter_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int MEM_WORDS       = 512;
    localparam int CYCLES_PER_LINE = 200;
    localparam int REQ_WAIT_LIMIT  = 20;
    localparam int EXTRA_WINDOW    = 20;

    logic       ap_clk;
    logic       areset_generator;
    logic       start;
    count_t     packet_count;
    logic       config_valid;
    filter_op_e config_op;
    data_t      config_threshold;
    logic       config_invert;
    logic       config_conditional;
    route_t     config_if_route;
    route_t     config_else_route;
    logic       in_valid;
    data_t      in_data;
    route_t     in_route;
    logic       out_ready;
    logic       in_full;
    logic       config_request;
    logic       out_valid;
    data_t      out_data;
    route_t     out_route;
    logic       done;

    logic [31:0] vec_mem [MEM_WORDS];
    data_t       exp_data_q [$];
    route_t      exp_route_q [$];
    int          rd_idx;
    int          mismatch_count;
    int          failure_count;
    int          cycle_count;
    int          cycle_limit;
    int          cfg_req_seen;
    int          out_seen_run;
    logic        request_seen;

    filter_cond_engine #(
        .FIFO_DEPTH (FIFO_DEPTH_DEFAULT),
        .PROG_THRESH(PROG_THRESH_DEFAULT)
    ) DUT (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .packet_count      (packet_count),
        .config_valid      (config_valid),
        .config_op         (config_op),
        .config_threshold  (config_threshold),
        .config_invert     (config_invert),
        .config_conditional(config_conditional),
        .config_if_route   (config_if_route),
        .config_else_route (config_else_route),
        .in_valid          (in_valid),
        .in_data           (in_data),
        .in_route          (in_route),
        .out_ready         (out_ready),
        .in_full           (in_full),
        .config_request    (config_request),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_route         (out_route),
        .done              (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // Run limit watcher armed once the vectors are counted
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_route(input string name, input route_t got, input route_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Output sample taken mid-cycle
    task automatic collect_output();
        if (!request_seen) begin
            report_failure("output appeared before config_request");
        end
        if (exp_data_q.size() == 0) begin
            report_failure($sformatf("extra output data 0x%h route 0x%h", out_data, out_route));
        end else begin
            check_data("out_data", out_data, exp_data_q.pop_front());
            check_route("out_route", out_route, exp_route_q.pop_front());
        end
        out_seen_run++;
    endtask

    // Every cycle after reset passes through here
    task automatic next_cycle();
        @(negedge ap_clk);
        if (config_request === 1'b1) begin
            cfg_req_seen++;
        end
        if (out_valid === 1'b1) begin
            collect_output();
        end
    endtask

    task automatic drive_ready(input logic hold_low);
        int rand_word;
        rand_word = $urandom;
        out_ready = hold_low ? 1'b0 : rand_word[0];
    endtask

    // ------------------------------
    // One run from the vector memory
    // ------------------------------
    task automatic run_filter(input int run_no);
        count_t     pkt_count;
        filter_op_e op;
        data_t      threshold;
        logic       invert;
        logic       cond;
        route_t     if_route;
        route_t     else_route;
        int         exp_count;
        int         stall;
        int         req_base;
        int         wait_cycles;
        int         run_limit;
        int         left_over;

        pkt_count  = vec_mem[rd_idx][15:0];
        op         = filter_op_e'(vec_mem[rd_idx + 1][1:0]);
        threshold  = vec_mem[rd_idx + 2];
        invert     = vec_mem[rd_idx + 3][0];
        cond       = vec_mem[rd_idx + 4][0];
        if_route   = vec_mem[rd_idx + 5][3:0];
        else_route = vec_mem[rd_idx + 6][3:0];
        exp_count  = vec_mem[rd_idx + 7];
        stall      = vec_mem[rd_idx + 8];
        rd_idx += 9;
        request_seen = 1'b0;
        out_seen_run = 0;

        // Preload the input FIFO
        for (int i = 0; i < pkt_count; i++) begin
            next_cycle();
            if (in_full) begin
                report_failure("input FIFO full while loading packets");
            end
            in_valid = 1'b1;
            in_data  = vec_mem[rd_idx];
            in_route = vec_mem[rd_idx + 1][3:0];
            rd_idx += 2;
        end
        next_cycle();
        in_valid = 1'b0;
        for (int i = 0; i < exp_count; i++) begin
            exp_data_q.push_back(vec_mem[rd_idx]);
            exp_route_q.push_back(vec_mem[rd_idx + 1][3:0]);
            rd_idx += 2;
        end

        req_base     = cfg_req_seen;
        start        = 1'b1;
        packet_count = pkt_count;
        next_cycle();
        start = 1'b0;
        wait_cycles = 0;
        while (cfg_req_seen == req_base && wait_cycles < REQ_WAIT_LIMIT) begin
            next_cycle();
            wait_cycles++;
        end
        if (cfg_req_seen == req_base) begin
            report_failure($sformatf("run %0d got no config_request after start", run_no));
        end
        request_seen = 1'b1;

        // Answer the request a little later
        repeat (2) next_cycle();
        config_valid       = 1'b1;
        config_op          = op;
        config_threshold   = threshold;
        config_invert      = invert;
        config_conditional = cond;
        config_if_route    = if_route;
        config_else_route  = else_route;
        next_cycle();
        config_valid = 1'b0;

        wait_cycles = 0;
        run_limit   = CYCLES_PER_LINE * (pkt_count + 1) + stall;
        while (done !== 1'b1 && wait_cycles < run_limit) begin
            drive_ready(wait_cycles < stall);
            next_cycle();
            wait_cycles++;
        end
        if (done !== 1'b1) begin
            report_failure($sformatf("run %0d never raised done", run_no));
        end

        // Once done is high the output FIFO holds every remaining packet
        out_ready = 1'b1;
        left_over = exp_data_q.size();
        for (int i = 0; i < left_over; i++) begin
            next_cycle();
            if (out_valid !== 1'b1) begin
                report_failure($sformatf("run %0d output FIFO ran dry after done", run_no));
            end
        end
        repeat (EXTRA_WINDOW) next_cycle();
        out_ready = 1'b0;

        if (out_seen_run != exp_count) begin
            report_failure($sformatf("run %0d read %0d outputs, expected %0d",
                run_no, out_seen_run, exp_count));
        end
        if (cfg_req_seen != req_base + 1) begin
            report_failure($sformatf("run %0d saw %0d config_request pulses",
                run_no, cfg_req_seen - req_base));
        end
        if (done !== 1'b1) begin
            report_failure($sformatf("run %0d dropped done before the next start", run_no));
        end
        exp_data_q.delete();
        exp_route_q.delete();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int num_runs;
        int records;
        int scan_idx;
        int seed;
        int first_rand;

        areset_generator   = 1'b1;
        start              = 1'b0;
        packet_count       = '0;
        config_valid       = 1'b0;
        config_op          = OP_EQ;
        config_threshold   = '0;
        config_invert      = 1'b0;
        config_conditional = 1'b0;
        config_if_route    = '0;
        config_else_route  = '0;
        in_valid           = 1'b0;
        in_data            = '0;
        in_route           = '0;
        out_ready          = 1'b0;
        mismatch_count     = 0;
        failure_count      = 0;
        cfg_req_seen       = 0;
        request_seen       = 1'b0;
        seed               = 80603;
        first_rand         = $urandom(seed);

        $readmemh("testbench/filter_input_vectors.txt", vec_mem);
        num_runs = 0;
        if ($isunknown(vec_mem[0])) begin
            report_failure("vector file could not be read");
        end else begin
            num_runs = vec_mem[0];
        end

        // Count records to size the run limit
        records  = 0;
        scan_idx = 1;
        for (int r = 0; r < num_runs; r++) begin
            records  += 1 + vec_mem[scan_idx] + vec_mem[scan_idx + 7];
            scan_idx += 9 + 2 * vec_mem[scan_idx] + 2 * vec_mem[scan_idx + 7];
        end
        cycle_limit = CYCLES_PER_LINE * (records + 1);

        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        next_cycle();
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("config_request", config_request, 1'b0);
        check_flag("in_full", in_full, 1'b0);

        rd_idx = 1;
        for (int r = 0; r < num_runs; r++) begin
            run_filter(r);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/filter_pkg.sv
source/sync_fifo.sv
source/filter_control.sv
source/filter_compare_stage.sv
source/filter_route_stage.sv
source/filter_cond_engine.sv
testbench/tb_filter_cond_engine.sv

// ==== testbench/filter_input_vectors.txt ====
// First word: number of runs. Each run: count op threshold invert conditional if_route else_route
// expected_count stall_cycles, then data/route pairs of the packets, then of the expected outputs
6
4 0 10 0 0 0 0 2 0
10 1 22 2 10 3 5 4
10 1 10 3
3 1 22 1 0 0 0 2 0
22 5 30 6 22 7
22 5 22 7
4 2 80000000 0 0 0 0 2 0
7FFFFFFF 1 80000000 2 FFFFFFFF 3 0 4
7FFFFFFF 1 0 4
4 3 100 0 0 0 0 2 0
101 8 100 9 FFFFFFF0 A FF B
101 8 FFFFFFF0 A
3 3 100 0 1 C 3 3 0
200 0 50 1 100 2
200 C 50 3 100 3
E 0 0 1 1 E 1 E 3C
0 5 1 5 2 5 3 5 4 5 5 5 6 5
7 5 8 5 9 5 A 5 B 5 C 5 D 5
0 1 1 E 2 E 3 E 4 E 5 E 6 E
7 E 8 E 9 E A E B E C E D E
